//--- src/IsaPkg.sv
package IsaPkg;

  typedef logic [31:0] Instruction;
  typedef logic [4:0] RegAddr;
  typedef logic [31:0] BasicData;
  typedef logic [2:0] Funct3;
  typedef logic [6:0] Funct7;
  typedef logic [6:0] Opcode;

  localparam RegAddr RegNone = 5'd0;

  // Major opcodes
  localparam Opcode OpImm = 7'b0010011;
  localparam Opcode OpReg = 7'b0110011;
  localparam Opcode OpLui = 7'b0110111;
  localparam Opcode OpAuipc = 7'b0010111;
  localparam Opcode OpJal = 7'b1101111;
  localparam Opcode OpJalr = 7'b1100111;
  localparam Opcode OpBranch = 7'b1100011;
  localparam Opcode OpStore = 7'b0100011;
  localparam Opcode OpLoad = 7'b0000011;

  // ALU funct3, shared by OP and OP-IMM
  localparam Funct3 F3AddSub = 3'b000;
  localparam Funct3 F3Sll = 3'b001;
  localparam Funct3 F3Slt = 3'b010;
  localparam Funct3 F3Sltu = 3'b011;
  localparam Funct3 F3Xor = 3'b100;
  localparam Funct3 F3SrlSra = 3'b101;
  localparam Funct3 F3Or = 3'b110;
  localparam Funct3 F3And = 3'b111;

  // Branch funct3
  localparam Funct3 F3Beq = 3'b000;
  localparam Funct3 F3Bne = 3'b001;
  localparam Funct3 F3Blt = 3'b100;
  localparam Funct3 F3Bge = 3'b101;
  localparam Funct3 F3Bltu = 3'b110;
  localparam Funct3 F3Bgeu = 3'b111;

  // Load and store width funct3
  localparam Funct3 F3Byte = 3'b000;
  localparam Funct3 F3Half = 3'b001;
  localparam Funct3 F3Word = 3'b010;
  localparam Funct3 F3ByteU = 3'b100;
  localparam Funct3 F3HalfU = 3'b101;

  // SUB and SRA/SRAI
  localparam Funct7 Funct7Alt = 7'b0100000;

endpackage

//--- src/CtrlPkg.sv
package CtrlPkg;

  typedef enum logic [3:0] {
    AluAdd,
    AluSub,
    AluSll,
    AluSlt,
    AluSltu,
    AluXor,
    AluSrl,
    AluSra,
    AluOr,
    AluAnd,
    AluPassB,
    AluNone
  } AluCode;

  // Operand source
  typedef enum logic [1:0] {
    OpTypeReg,
    OpTypeImm,
    OpTypePc,
    OpTypeNone
  } OperandType;

  typedef enum logic [3:0] {
    BrNone,
    BrEq,
    BrNe,
    BrLt,
    BrGe,
    BrLtu,
    BrGeu,
    BrJal,
    BrJalr
  } BrCtrl;

  typedef enum logic [2:0] {
    MemNone,
    MemByte,
    MemHalf,
    MemWord,
    MemByteU,
    MemHalfU
  } MemWidth;

endpackage

//--- src/Decoder.sv
`timescale 1ns/1ps

module Decoder (
  input var IsaPkg::Instruction inst,
  output var IsaPkg::RegAddr rs1Addr,
  output var IsaPkg::RegAddr rs2Addr,
  output var IsaPkg::RegAddr rdAddr,
  output var IsaPkg::BasicData imm,
  output var CtrlPkg::AluCode aluCode,
  output var CtrlPkg::OperandType op1Type,
  output var CtrlPkg::OperandType op2Type,
  output var CtrlPkg::BrCtrl brCtrl,
  output var CtrlPkg::MemWidth memWidth,
  output var logic wEnable,
  output var logic isLoad,
  output var logic isStore,
  output var logic isBubble
);

  IsaPkg::Opcode opcode;
  IsaPkg::Funct3 funct3;
  IsaPkg::Funct7 funct7;
  IsaPkg::BasicData immI;
  IsaPkg::BasicData immS;
  IsaPkg::BasicData immB;
  IsaPkg::BasicData immU;
  IsaPkg::BasicData immJ;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'b0};
  assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // Subtract only exists in OP, shifts honour alt in both forms
  function automatic CtrlPkg::AluCode aluSelect(input IsaPkg::Funct3 f3, input logic alt,
                                                input logic isReg);
    case (f3)
      IsaPkg::F3AddSub: return (isReg && alt) ? CtrlPkg::AluSub : CtrlPkg::AluAdd;
      IsaPkg::F3Sll: return CtrlPkg::AluSll;
      IsaPkg::F3Slt: return CtrlPkg::AluSlt;
      IsaPkg::F3Sltu: return CtrlPkg::AluSltu;
      IsaPkg::F3Xor: return CtrlPkg::AluXor;
      IsaPkg::F3SrlSra: return alt ? CtrlPkg::AluSra : CtrlPkg::AluSrl;
      IsaPkg::F3Or: return CtrlPkg::AluOr;
      default: return CtrlPkg::AluAnd;
    endcase
  endfunction

  function automatic CtrlPkg::BrCtrl brSelect(input IsaPkg::Funct3 f3);
    case (f3)
      IsaPkg::F3Beq: return CtrlPkg::BrEq;
      IsaPkg::F3Bne: return CtrlPkg::BrNe;
      IsaPkg::F3Blt: return CtrlPkg::BrLt;
      IsaPkg::F3Bge: return CtrlPkg::BrGe;
      IsaPkg::F3Bltu: return CtrlPkg::BrLtu;
      IsaPkg::F3Bgeu: return CtrlPkg::BrGeu;
      default: return CtrlPkg::BrNone;
    endcase
  endfunction

  function automatic CtrlPkg::MemWidth memSelect(input IsaPkg::Funct3 f3);
    case (f3)
      IsaPkg::F3Byte: return CtrlPkg::MemByte;
      IsaPkg::F3Half: return CtrlPkg::MemHalf;
      IsaPkg::F3Word: return CtrlPkg::MemWord;
      IsaPkg::F3ByteU: return CtrlPkg::MemByteU;
      IsaPkg::F3HalfU: return CtrlPkg::MemHalfU;
      default: return CtrlPkg::MemNone;
    endcase
  endfunction

  always_comb begin
    rs1Addr = IsaPkg::RegNone;
    rs2Addr = IsaPkg::RegNone;
    rdAddr = IsaPkg::RegNone;
    imm = '0;
    aluCode = CtrlPkg::AluNone;
    op1Type = CtrlPkg::OpTypeNone;
    op2Type = CtrlPkg::OpTypeNone;
    brCtrl = CtrlPkg::BrNone;
    memWidth = CtrlPkg::MemNone;
    wEnable = 1'b0;
    isLoad = 1'b0;
    isStore = 1'b0;
    isBubble = 1'b0;

    unique case (opcode)
      IsaPkg::OpImm: begin
        rs1Addr = inst[19:15];
        rdAddr = inst[11:7];
        imm = immI;
        aluCode = aluSelect(funct3, funct7[5], 1'b0);
        op1Type = CtrlPkg::OpTypeReg;
        op2Type = CtrlPkg::OpTypeImm;
        wEnable = 1'b1;
      end
      IsaPkg::OpReg: begin
        rs1Addr = inst[19:15];
        rs2Addr = inst[24:20];
        rdAddr = inst[11:7];
        aluCode = aluSelect(funct3, funct7 == IsaPkg::Funct7Alt, 1'b1);
        op1Type = CtrlPkg::OpTypeReg;
        op2Type = CtrlPkg::OpTypeReg;
        wEnable = 1'b1;
      end
      IsaPkg::OpLui, IsaPkg::OpAuipc: begin
        rdAddr = inst[11:7];
        imm = immU;
        aluCode = (opcode == IsaPkg::OpLui) ? CtrlPkg::AluPassB : CtrlPkg::AluAdd;
        op1Type = CtrlPkg::OpTypePc;
        op2Type = CtrlPkg::OpTypeImm;
        wEnable = 1'b1;
      end
      IsaPkg::OpJal: begin
        rdAddr = inst[11:7];
        imm = immJ;
        brCtrl = CtrlPkg::BrJal;
        wEnable = 1'b1;
      end
      IsaPkg::OpJalr: begin
        rs1Addr = inst[19:15];
        rdAddr = inst[11:7];
        imm = immI;
        brCtrl = CtrlPkg::BrJalr;
        wEnable = 1'b1;
      end
      IsaPkg::OpBranch: begin
        rs1Addr = inst[19:15];
        rs2Addr = inst[24:20];
        imm = immB;
        brCtrl = brSelect(funct3);
      end
      IsaPkg::OpStore: begin
        rs1Addr = inst[19:15];
        rs2Addr = inst[24:20];
        imm = immS;
        aluCode = CtrlPkg::AluAdd;
        op1Type = CtrlPkg::OpTypeReg;
        op2Type = CtrlPkg::OpTypeImm;
        memWidth = memSelect(funct3);
        isStore = 1'b1;
      end
      IsaPkg::OpLoad: begin
        rs1Addr = inst[19:15];
        rdAddr = inst[11:7];
        imm = immI;
        aluCode = CtrlPkg::AluAdd;
        op1Type = CtrlPkg::OpTypeReg;
        op2Type = CtrlPkg::OpTypeImm;
        memWidth = memSelect(funct3);
        wEnable = 1'b1;
        isLoad = 1'b1;
      end
      default: begin
        isBubble = 1'b1;
      end
    endcase
  end

endmodule

//--- src/RegFile.sv
`timescale 1ns/1ps

module RegFile (
  input var logic clk,
  input var logic rstN,
  input var logic we,
  input var IsaPkg::RegAddr wAddr,
  input var IsaPkg::BasicData wData,
  input var IsaPkg::RegAddr rAddr1,
  input var IsaPkg::RegAddr rAddr2,
  output var IsaPkg::BasicData rData1,
  output var IsaPkg::BasicData rData2
);

  // x0 has no storage
  IsaPkg::BasicData regs [1:31];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wAddr != IsaPkg::RegNone) begin
      regs[wAddr] <= wData;
    end
  end

  assign rData1 = (rAddr1 == IsaPkg::RegNone) ? '0 : regs[rAddr1];
  assign rData2 = (rAddr2 == IsaPkg::RegNone) ? '0 : regs[rAddr2];

endmodule

//--- src/ExecUnit.sv
`timescale 1ns/1ps

module ExecUnit (
  input var CtrlPkg::AluCode aluCode,
  input var CtrlPkg::OperandType op1Type,
  input var CtrlPkg::OperandType op2Type,
  input var CtrlPkg::BrCtrl brCtrl,
  input var IsaPkg::BasicData rs1Data,
  input var IsaPkg::BasicData rs2Data,
  input var IsaPkg::BasicData imm,
  input var IsaPkg::BasicData pc,
  output var IsaPkg::BasicData result,
  output var IsaPkg::BasicData linkPc,
  output var logic branchTaken,
  output var IsaPkg::BasicData targetPc
);

  IsaPkg::BasicData op1;
  IsaPkg::BasicData op2;
  IsaPkg::BasicData jalrSum;
  logic [4:0] shamt;

  always_comb begin
    case (op1Type)
      CtrlPkg::OpTypeReg: op1 = rs1Data;
      CtrlPkg::OpTypeImm: op1 = imm;
      CtrlPkg::OpTypePc: op1 = pc;
      default: op1 = '0;
    endcase
    case (op2Type)
      CtrlPkg::OpTypeReg: op2 = rs2Data;
      CtrlPkg::OpTypeImm: op2 = imm;
      default: op2 = '0;
    endcase
  end

  assign shamt = op2[4:0];

  always_comb begin
    case (aluCode)
      CtrlPkg::AluAdd: result = op1 + op2;
      CtrlPkg::AluSub: result = op1 - op2;
      CtrlPkg::AluSll: result = op1 << shamt;
      CtrlPkg::AluSlt: result = {31'd0, $signed(op1) < $signed(op2)};
      CtrlPkg::AluSltu: result = {31'd0, op1 < op2};
      CtrlPkg::AluXor: result = op1 ^ op2;
      CtrlPkg::AluSrl: result = op1 >> shamt;
      CtrlPkg::AluSra: result = $signed(op1) >>> shamt;
      CtrlPkg::AluOr: result = op1 | op2;
      CtrlPkg::AluAnd: result = op1 & op2;
      CtrlPkg::AluPassB: result = op2;
      default: result = '0;
    endcase
  end

  // Compare works on the register values directly
  always_comb begin
    case (brCtrl)
      CtrlPkg::BrEq: branchTaken = rs1Data == rs2Data;
      CtrlPkg::BrNe: branchTaken = rs1Data != rs2Data;
      CtrlPkg::BrLt: branchTaken = $signed(rs1Data) < $signed(rs2Data);
      CtrlPkg::BrGe: branchTaken = $signed(rs1Data) >= $signed(rs2Data);
      CtrlPkg::BrLtu: branchTaken = rs1Data < rs2Data;
      CtrlPkg::BrGeu: branchTaken = rs1Data >= rs2Data;
      CtrlPkg::BrJal, CtrlPkg::BrJalr: branchTaken = 1'b1;
      default: branchTaken = 1'b0;
    endcase
  end

  assign jalrSum = rs1Data + imm;
  assign targetPc = (brCtrl == CtrlPkg::BrJalr) ? {jalrSum[31:1], 1'b0} : pc + imm;
  assign linkPc = pc + 32'd4;

endmodule

//--- src/DataMem.sv
`timescale 1ns/1ps

module DataMem #(
  parameter int MemWords = 256
) (
  input var logic clk,
  input var logic writeEn,
  input var IsaPkg::BasicData addr,
  input var IsaPkg::BasicData wData,
  input var CtrlPkg::MemWidth width,
  output var IsaPkg::BasicData rData
);

  localparam int IdxWidth = $clog2(MemWords);

  IsaPkg::BasicData mem [MemWords];
  logic [IdxWidth-1:0] wordIdx;
  logic [3:0] byteEn;
  IsaPkg::BasicData laneData;
  IsaPkg::BasicData word;
  logic [7:0] selByte;
  logic [15:0] selHalf;

  assign wordIdx = addr[IdxWidth+1:2];

  // Replicate narrow data across lanes
  always_comb begin
    case (width)
      CtrlPkg::MemByte, CtrlPkg::MemByteU: begin
        byteEn = 4'b0001 << addr[1:0];
        laneData = {4{wData[7:0]}};
      end
      CtrlPkg::MemHalf, CtrlPkg::MemHalfU: begin
        byteEn = addr[1] ? 4'b1100 : 4'b0011;
        laneData = {2{wData[15:0]}};
      end
      CtrlPkg::MemWord: begin
        byteEn = 4'b1111;
        laneData = wData;
      end
      default: begin
        byteEn = 4'b0000;
        laneData = wData;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (writeEn) begin
      for (int i = 0; i < 4; i++) begin
        if (byteEn[i]) begin
          mem[wordIdx][8*i +: 8] <= laneData[8*i +: 8];
        end
      end
    end
  end

  assign word = mem[wordIdx];
  assign selByte = word[{addr[1:0], 3'b000} +: 8];
  assign selHalf = addr[1] ? word[31:16] : word[15:0];

  always_comb begin
    case (width)
      CtrlPkg::MemByte: rData = {{24{selByte[7]}}, selByte};
      CtrlPkg::MemByteU: rData = {24'd0, selByte};
      CtrlPkg::MemHalf: rData = {{16{selHalf[15]}}, selHalf};
      CtrlPkg::MemHalfU: rData = {16'd0, selHalf};
      CtrlPkg::MemWord: rData = word;
      default: rData = '0;
    endcase
  end

endmodule

//--- src/CoreTop.sv
`timescale 1ns/1ps

module CoreTop #(
  parameter int MemWords = 256
) (
  input var logic clk,
  input var logic rstN,
  input var logic instValid,
  input var IsaPkg::Instruction inst,
  input var IsaPkg::BasicData pc,
  output var logic wbValid,
  output var IsaPkg::RegAddr wbAddr,
  output var IsaPkg::BasicData wbData,
  output var logic redirect,
  output var IsaPkg::BasicData redirectPc,
  output var logic illegal
);

  IsaPkg::RegAddr rs1Addr;
  IsaPkg::RegAddr rs2Addr;
  IsaPkg::RegAddr rdAddr;
  IsaPkg::BasicData imm;
  CtrlPkg::AluCode aluCode;
  CtrlPkg::OperandType op1Type;
  CtrlPkg::OperandType op2Type;
  CtrlPkg::BrCtrl brCtrl;
  CtrlPkg::MemWidth memWidth;
  logic wEnable;
  logic isLoad;
  logic isStore;
  logic isBubble;
  IsaPkg::BasicData rs1Data;
  IsaPkg::BasicData rs2Data;
  IsaPkg::BasicData result;
  IsaPkg::BasicData linkPc;
  logic branchTaken;
  IsaPkg::BasicData targetPc;
  IsaPkg::BasicData memRData;
  IsaPkg::BasicData wbValue;
  logic regWe;
  logic memWe;

  Decoder decoder (
    .inst(inst),
    .rs1Addr(rs1Addr),
    .rs2Addr(rs2Addr),
    .rdAddr(rdAddr),
    .imm(imm),
    .aluCode(aluCode),
    .op1Type(op1Type),
    .op2Type(op2Type),
    .brCtrl(brCtrl),
    .memWidth(memWidth),
    .wEnable(wEnable),
    .isLoad(isLoad),
    .isStore(isStore),
    .isBubble(isBubble)
  );

  RegFile regFile (
    .clk(clk),
    .rstN(rstN),
    .we(regWe),
    .wAddr(rdAddr),
    .wData(wbValue),
    .rAddr1(rs1Addr),
    .rAddr2(rs2Addr),
    .rData1(rs1Data),
    .rData2(rs2Data)
  );

  ExecUnit execUnit (
    .aluCode(aluCode),
    .op1Type(op1Type),
    .op2Type(op2Type),
    .brCtrl(brCtrl),
    .rs1Data(rs1Data),
    .rs2Data(rs2Data),
    .imm(imm),
    .pc(pc),
    .result(result),
    .linkPc(linkPc),
    .branchTaken(branchTaken),
    .targetPc(targetPc)
  );

  // ALU result doubles as the load/store address
  DataMem #(
    .MemWords(MemWords)
  ) dataMem (
    .clk(clk),
    .writeEn(memWe),
    .addr(result),
    .wData(rs2Data),
    .width(memWidth),
    .rData(memRData)
  );

  assign regWe = instValid && wEnable;
  assign memWe = instValid && isStore;

  always_comb begin
    if (isLoad) begin
      wbValue = memRData;
    end else if (brCtrl == CtrlPkg::BrJal || brCtrl == CtrlPkg::BrJalr) begin
      wbValue = linkPc;
    end else begin
      wbValue = result;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wbValid <= 1'b0;
      wbAddr <= IsaPkg::RegNone;
      wbData <= '0;
      redirect <= 1'b0;
      redirectPc <= '0;
      illegal <= 1'b0;
    end else begin
      // Pulses fall whenever no instruction came in
      wbValid <= regWe && rdAddr != IsaPkg::RegNone;
      redirect <= instValid && branchTaken;
      illegal <= instValid && isBubble;
      if (instValid) begin
        wbAddr <= rdAddr;
        wbData <= wbValue;
        redirectPc <= targetPc;
      end
    end
  end

endmodule

//--- tb/CoreTb_sva.sv
`timescale 1ns/1ps

module CoreTbSva (
  input var logic clk,
  input var logic rstN,
  input var logic instValid,
  input var logic wbValid,
  input var IsaPkg::RegAddr wbAddr,
  input var IsaPkg::BasicData wbData,
  input var logic redirect,
  input var IsaPkg::BasicData redirectPc,
  input var logic illegal
);

  // Pulses only follow an accepted instruction
  pulsesIdle: assert property (@(posedge clk) disable iff (!rstN)
    !instValid |=> !wbValid && !redirect && !illegal)
    else $error("output pulse without an instruction on the previous edge");

  wbAddrNonZero: assert property (@(posedge clk) disable iff (!rstN)
    wbValid |-> wbAddr != IsaPkg::RegNone)
    else $error("write-back reported for register x0");

  resetClears: assert property (@(posedge clk)
    !rstN |=> !wbValid && !redirect && !illegal && wbAddr == IsaPkg::RegNone
      && wbData == '0 && redirectPc == '0)
    else $error("outputs not cleared by reset");

endmodule

//--- tb/CoreTb.sv
`timescale 1ns/1ps

module CoreTb;

  localparam int ClkPeriod = 40;
  localparam int ResetCycles = 16;
  localparam int MaxInsts = 200;
  localparam int WatchdogNs = (MaxInsts * 3 + ResetCycles) * ClkPeriod;

  logic clk;
  logic rstN;
  logic instValid;
  logic [31:0] inst;
  logic [31:0] pc;
  logic wbValid;
  logic [4:0] wbAddr;
  logic [31:0] wbData;
  logic redirect;
  logic [31:0] redirectPc;
  logic illegal;

  logic [31:0] rngState;
  logic [31:0] pcCur;
  logic [31:0] regModel [32];
  logic [31:0] memModel [256];
  // {inst, wbValid, wbAddr, wbData, redirect, redirectPc, illegal}
  logic [103:0] expQ [$];
  int errorCount;
  int testCount;
  int failedTests;

  CoreTop #(
    .MemWords(256)
  ) uut (
    .clk(clk),
    .rstN(rstN),
    .instValid(instValid),
    .inst(inst),
    .pc(pc),
    .wbValid(wbValid),
    .wbAddr(wbAddr),
    .wbData(wbData),
    .redirect(redirect),
    .redirectPc(redirectPc),
    .illegal(illegal)
  );

  bind CoreTop CoreTbSva coreSva (
    .clk(clk),
    .rstN(rstN),
    .instValid(instValid),
    .wbValid(wbValid),
    .wbAddr(wbAddr),
    .wbData(wbData),
    .redirect(redirect),
    .redirectPc(redirectPc),
    .illegal(illegal)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  function automatic logic [31:0] randWord();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, IsaPkg::OpReg};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], IsaPkg::OpStore};
  endfunction

  function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], IsaPkg::OpBranch};
  endfunction

  function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, IsaPkg::OpJal};
  endfunction

  function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: return (a < b) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branchRef(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      3'b111: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] loadRef(input logic [2:0] f3, input logic [31:0] w,
                                          input logic [1:0] off);
    logic [7:0] by;
    logic [15:0] hw;
    by = w[8*off +: 8];
    hw = off[1] ? w[31:16] : w[15:0];
    case (f3)
      3'b000: return {{24{by[7]}}, by};
      3'b001: return {{16{hw[15]}}, hw};
      3'b100: return {24'h0, by};
      3'b101: return {16'h0, hw};
      default: return w;
    endcase
  endfunction

  function automatic logic [31:0] storeRef(input logic [2:0] f3, input logic [31:0] old,
                                           input logic [31:0] data, input logic [1:0] off);
    logic [31:0] w;
    w = old;
    case (f3)
      3'b000: w[8*off +: 8] = data[7:0];
      3'b001: w[16*off[1] +: 16] = data[15:0];
      default: w = data;
    endcase
    return w;
  endfunction

  // Architectural step of one instruction and the report the core owes for it
  task automatic predict(input logic [31:0] ins, input logic [31:0] pcv);
    logic [4:0] rd;
    logic [2:0] f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immJ;
    logic [31:0] addr;
    logic [31:0] val;
    logic [31:0] tgt;
    logic wr;
    logic red;
    logic ill;
    rd = ins[11:7];
    f3 = ins[14:12];
    a = regModel[ins[19:15]];
    b = regModel[ins[24:20]];
    immI = {{20{ins[31]}}, ins[31:20]};
    immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    wr = 1'b0;
    red = 1'b0;
    ill = 1'b0;
    val = '0;
    tgt = '0;
    case (ins[6:0])
      IsaPkg::OpImm: begin
        wr = 1'b1;
        val = aluRef(f3, f3 == 3'b101 && ins[30], a, immI);
      end
      IsaPkg::OpReg: begin
        wr = 1'b1;
        val = aluRef(f3, ins[30], a, b);
      end
      IsaPkg::OpLui: begin
        wr = 1'b1;
        val = {ins[31:12], 12'h000};
      end
      IsaPkg::OpAuipc: begin
        wr = 1'b1;
        val = pcv + {ins[31:12], 12'h000};
      end
      IsaPkg::OpJal: begin
        wr = 1'b1;
        val = pcv + 32'd4;
        red = 1'b1;
        tgt = pcv + immJ;
      end
      IsaPkg::OpJalr: begin
        wr = 1'b1;
        val = pcv + 32'd4;
        red = 1'b1;
        tgt = (a + immI) & ~32'd1;
      end
      IsaPkg::OpBranch: begin
        red = branchRef(f3, a, b);
        tgt = pcv + immB;
      end
      IsaPkg::OpLoad: begin
        wr = 1'b1;
        addr = a + immI;
        val = loadRef(f3, memModel[addr[9:2]], addr[1:0]);
      end
      IsaPkg::OpStore: begin
        addr = a + immS;
        memModel[addr[9:2]] = storeRef(f3, memModel[addr[9:2]], b, addr[1:0]);
      end
      default: ill = 1'b1;
    endcase
    if (wr && rd != 5'd0) regModel[rd] = val;
    expQ.push_back({ins, wr && rd != 5'd0, rd, val, red, tgt, ill});
  endtask

  task automatic issue(input logic [31:0] ins);
    @(posedge clk);
    instValid <= 1'b1;
    inst <= ins;
    pc <= pcCur;
    pcCur = pcCur + 32'd4;
  endtask

  task automatic checkNext();
    logic [31:0] ins;
    logic eWb;
    logic [4:0] eAddr;
    logic [31:0] eData;
    logic eRed;
    logic [31:0] ePc;
    logic eIll;
    if (expQ.size() == 0) begin
      $display("No expected result was queued for this output cycle");
      errorCount++;
      return;
    end
    {ins, eWb, eAddr, eData, eRed, ePc, eIll} = expQ.pop_front();
    assert (wbValid === eWb) else begin
      $display("error wbValid expected %h actual %h for inst %h", eWb, wbValid, ins);
      errorCount++;
    end
    if (eWb) begin
      assert (wbAddr === eAddr) else begin
        $display("error wbAddr expected %h actual %h for inst %h", eAddr, wbAddr, ins);
        errorCount++;
      end
      assert (wbData === eData) else begin
        $display("error wbData expected %h actual %h for inst %h", eData, wbData, ins);
        errorCount++;
      end
    end
    assert (redirect === eRed) else begin
      $display("error redirect expected %h actual %h for inst %h", eRed, redirect, ins);
      errorCount++;
    end
    if (eRed) begin
      assert (redirectPc === ePc) else begin
        $display("error redirectPc expected %h actual %h for inst %h", ePc, redirectPc, ins);
        errorCount++;
      end
    end
    assert (illegal === eIll) else begin
      $display("error illegal expected %h actual %h for inst %h", eIll, illegal, ins);
      errorCount++;
    end
  endtask

  task automatic runOne(input logic [31:0] ins);
    predict(ins, pcCur);
    issue(ins);
    @(posedge clk);
    instValid <= 1'b0;
    @(negedge clk);
    checkNext();
  endtask

  // LUI plus ADDI with the upper part rounded for the sign of the low 12 bits
  task automatic loadReg(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] hi;
    hi = value + 32'h800;
    runOne(encU(hi[31:12], rd, IsaPkg::OpLui));
    runOne(encI(value[11:0], rd, 3'b000, rd, IsaPkg::OpImm));
  endtask

  task automatic reportTest(input string name, input int errorsAtStart);
    testCount++;
    if (errorCount == errorsAtStart) begin
      $display("test %s: ok", name);
    end else begin
      failedTests++;
      $display("test %s: %0d errors", name, errorCount - errorsAtStart);
    end
  endtask

  task automatic testAluOps();
    int startErr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [11:0] imm;
    startErr = errorCount;
    for (int f3 = 0; f3 < 8; f3++) begin
      for (int alt = 0; alt < 2; alt++) begin
        if (alt == 1 && f3 != 0 && f3 != 5) continue;
        a = randWord();
        b = randWord();
        // Opposite signs split SLT from SLTU
        if (f3 == 2 || f3 == 3) begin
          a[31] = 1'b1;
          b[31] = 1'b0;
        end
        loadReg(5'd5, a);
        loadReg(5'd6, b);
        runOne(encR(alt ? 7'h20 : 7'h00, 5'd6, 5'd5, 3'(f3), 5'd7));
      end
    end
    for (int f3 = 0; f3 < 8; f3++) begin
      for (int alt = 0; alt < 2; alt++) begin
        if (alt == 1 && f3 != 5) continue;
        loadReg(5'd8, randWord());
        r = randWord();
        imm = (f3 == 1 || f3 == 5) ? {alt ? 7'h20 : 7'h00, r[4:0]} : r[11:0];
        runOne(encI(imm, 5'd8, 3'(f3), 5'd9, IsaPkg::OpImm));
      end
    end
    runOne(encR(7'h00, 5'd6, 5'd5, 3'b000, 5'd0));
    runOne(encI(12'h000, 5'd0, 3'b000, 5'd10, IsaPkg::OpImm));
    reportTest("register ALU", startErr);
  endtask

  task automatic testUpperImm();
    int startErr;
    logic [31:0] r;
    startErr = errorCount;
    r = randWord();
    runOne(encU(r[31:12], 5'd11, IsaPkg::OpLui));
    repeat (3) begin
      r = randWord();
      pcCur = {r[31:2], 2'b00};
      r = randWord();
      runOne(encU(r[31:12], 5'd12, IsaPkg::OpAuipc));
    end
    reportTest("upper immediates", startErr);
  endtask

  task automatic testBranches();
    int startErr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    startErr = errorCount;
    for (int c = 0; c < 4; c++) begin
      r = randWord();
      a = {2'b00, r[29:0]};
      case (c)
        0: b = a;
        1: b = a + 32'd100;
        2: begin
          b = a;
          a = {1'b1, r[30:0]};
        end
        default: b = a >> 1;
      endcase
      loadReg(5'd13, a);
      loadReg(5'd14, b);
      for (int f3 = 0; f3 < 8; f3++) begin
        if (f3 == 2 || f3 == 3) continue;
        r = randWord();
        runOne(encB({r[12:1], 1'b0}, 5'd14, 5'd13, 3'(f3)));
      end
    end
    r = randWord();
    runOne(encJ({r[20:1], 1'b0}, 5'd1));
    // Odd sum so the cleared bit 0 shows
    r = randWord();
    loadReg(5'd15, {r[31:1], 1'b1});
    runOne(encI({r[11:1], 1'b0}, 5'd15, 3'b000, 5'd1, IsaPkg::OpJalr));
    runOne(encI(r[11:0], 5'd15, 3'b000, 5'd15, IsaPkg::OpJalr));
    reportTest("branches and jumps", startErr);
  endtask

  task automatic loadAll(input logic [11:0] base);
    for (int off = 0; off < 4; off++) begin
      runOne(encI(base + 12'(off), 5'd16, 3'b000, 5'd18, IsaPkg::OpLoad));
      runOne(encI(base + 12'(off), 5'd16, 3'b100, 5'd18, IsaPkg::OpLoad));
      if (off % 2 == 0) begin
        runOne(encI(base + 12'(off), 5'd16, 3'b001, 5'd18, IsaPkg::OpLoad));
        runOne(encI(base + 12'(off), 5'd16, 3'b101, 5'd18, IsaPkg::OpLoad));
      end
      if (off == 0) runOne(encI(base, 5'd16, 3'b010, 5'd18, IsaPkg::OpLoad));
    end
  endtask

  task automatic testMemory();
    int startErr;
    startErr = errorCount;
    loadReg(5'd16, 32'h0000_0100);
    loadReg(5'd17, randWord());
    runOne(encS(12'd0, 5'd17, 5'd16, 3'b010));
    runOne(encS(12'd4, 5'd17, 5'd16, 3'b010));
    // Word stores read back before the narrow stores cover them
    runOne(encI(12'd0, 5'd16, 3'b010, 5'd18, IsaPkg::OpLoad));
    runOne(encI(12'd4, 5'd16, 3'b010, 5'd18, IsaPkg::OpLoad));
    for (int off = 0; off < 4; off++) begin
      loadReg(5'd17, randWord());
      runOne(encS(12'(off), 5'd17, 5'd16, 3'b000));
    end
    loadAll(12'd0);
    for (int off = 0; off < 4; off += 2) begin
      loadReg(5'd17, randWord());
      runOne(encS(12'd4 + 12'(off), 5'd17, 5'd16, 3'b001));
    end
    loadAll(12'd4);
    reportTest("memory", startErr);
  endtask

  task automatic testChainIllegal();
    int startErr;
    logic [31:0] r;
    logic [31:0] ins;
    startErr = errorCount;
    loadReg(5'd19, randWord());
    // Each ADDI is captured on the edge that drives the next one
    for (int k = 0; k < 8; k++) begin
      r = randWord();
      ins = encI(r[11:0], 5'd19, 3'b000, 5'd19, IsaPkg::OpImm);
      predict(ins, pcCur);
      issue(ins);
      if (k > 0) begin
        @(negedge clk);
        checkNext();
      end
    end
    @(posedge clk);
    instValid <= 1'b0;
    @(negedge clk);
    checkNext();
    r = randWord();
    runOne({r[31:7], 7'b1110011});
    @(negedge clk);
    assert (illegal === 1'b0) else begin
      $display("error illegal expected %h actual %h one cycle after the pulse", 1'b0, illegal);
      errorCount++;
    end
    reportTest("dependent chain and illegal opcode", startErr);
  endtask

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns before the tests completed", WatchdogNs);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    instValid = 1'b0;
    inst = '0;
    pc = '0;
    rngState = 32'ha79125fc;
    pcCur = 32'h0000_1000;
    errorCount = 0;
    testCount = 0;
    failedTests = 0;
    for (int i = 0; i < 32; i++) begin
      regModel[i] = '0;
    end
    repeat (ResetCycles) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);
    testAluOps();
    testUpperImm();
    testBranches();
    testMemory();
    testChainIllegal();
    $display("Summary: %0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- list.f
src/IsaPkg.sv
src/CtrlPkg.sv
src/Decoder.sv
src/RegFile.sv
src/ExecUnit.sv
src/DataMem.sv
src/CoreTop.sv
tb/CoreTb_sva.sv
tb/CoreTb.sv

//--- run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module CoreTb -f list.f -o simCore \
  || { echo "Build failed"; exit 1; }
./obj_dir/simCore > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "Run failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "Run ended without a result"; exit 1; }
echo "Run passed"
